// ==== design/cnn_accel_pkg.sv ====
package cnn_accel_pkg;

    ////////////////////////////////////////
    // BRAM quad geometry
    ////////////////////////////////////////

    localparam int BRAM_DEPTH = 512;
    // Row and column index width
    localparam int ADDR_W = $clog2(BRAM_DEPTH);

    // Engines fed by one quad
    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int NUM_CE         = NUM_AWE * NUM_CE_PER_AWE;

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////

    // Last cycle index of one output pixel, six sequence reads per pixel
    localparam logic [2:0] CYCLE_COUNT = 3'd5;

    localparam int SEQ_ADDR_W = 12;
    localparam int PFB_CNT_W  = 10;

    // Input rows held before the first output row starts
    localparam int PRIME_ROWS = 4;

    // Cycles from sequence BRAM read enable to data out
    localparam int SEQ_RD_LATENCY = 3;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE          = 3'd0,
        ST_PRIME         = 3'd1,
        ST_WAIT_FETCH    = 3'd2,
        ST_ACTIVE        = 3'd3,
        ST_WAIT_JOB_DONE = 3'd4,
        ST_SEND_COMPLETE = 3'd5
    } quad_state_t;

endpackage

// ==== design/quad_ctrl_fsm.sv ====
`timescale 1ns/1ps

module quad_ctrl_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       job_start,
    input  logic                       job_fetch_ack,
    input  logic                       job_fetch_complete,
    input  logic                       job_complete_ack,
    input  logic                       pipeline_flushed,
    input  logic                       prime_done,
    input  logic                       row_loaded,
    input  logic                       pfb_empty,
    input  logic                       row_done,
    input  logic                       last_row,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_fetch_in_progress,
    output logic                       job_complete,
    output logic                       prime_en,
    output logic                       row_load_en,
    output logic                       seq_en,
    output logic                       seq_restart,
    output logic                       clear,
    output cnn_accel_pkg::quad_state_t state
);
    import cnn_accel_pkg::*;

    // State to resume once a fetch completes
    quad_state_t return_state;
    // Set while a fetched row still has to be read during a pass
    logic        load_pending;

    assign prime_en    = (state == ST_PRIME);
    assign seq_en      = (state == ST_ACTIVE);
    // Next input row is read while the pass runs
    assign row_load_en = seq_en && load_pending;
    // Complete acknowledge wipes every counter
    assign clear       = (state == ST_SEND_COMPLETE) && job_complete_ack;

    ////////////////////////////////////////
    // Job, fetch and row sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= ST_IDLE;
            return_state          <= ST_IDLE;
            job_accept            <= 1'b0;
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            job_complete          <= 1'b0;
            load_pending          <= 1'b0;
            seq_restart           <= 1'b0;
        end else begin
            // Single-cycle pulses
            job_accept  <= 1'b0;
            seq_restart <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    // Enough rows buffered, start the first pass
                    if (prime_done) begin
                        seq_restart <= 1'b1;
                        state       <= ST_ACTIVE;
                    end else if (pfb_empty) begin
                        return_state <= ST_PRIME;
                        state        <= ST_WAIT_FETCH;
                    end
                end
                ST_WAIT_FETCH: begin
                    // Request level drops once acked
                    if (job_fetch_ack) begin
                        job_fetch_request     <= 1'b0;
                        job_fetch_in_progress <= 1'b1;
                    end else if (!job_fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (job_fetch_complete) begin
                        job_fetch_in_progress <= 1'b0;
                        state                 <= return_state;
                        // Row fetch during the job, read it in the next pass
                        if (return_state == ST_ACTIVE) begin
                            load_pending <= 1'b1;
                            seq_restart  <= 1'b1;
                        end
                    end
                end
                ST_ACTIVE: begin
                    if (row_loaded) begin
                        load_pending <= 1'b0;
                    end
                    if (row_done) begin
                        if (last_row) begin
                            state <= ST_WAIT_JOB_DONE;
                        end else begin
                            return_state <= ST_ACTIVE;
                            state        <= ST_WAIT_FETCH;
                        end
                    end
                end
                ST_WAIT_JOB_DONE: begin
                    // CE chain must drain first
                    if (pipeline_flushed) begin
                        state <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        job_complete <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // No new fetch request while the previous fetch runs
    a_no_req_in_fetch: assert property (@(posedge clk) disable iff (rst)
        $rose(job_fetch_request) |-> !job_fetch_in_progress)
        else $error("fetch request raised during fetch in progress");

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {ST_IDLE, ST_PRIME, ST_WAIT_FETCH, ST_ACTIVE,
                      ST_WAIT_JOB_DONE, ST_SEND_COMPLETE})
        else $error("illegal controller state %0d", state);

endmodule

// ==== design/pfb_row_reader.sv ====
`timescale 1ns/1ps

module pfb_row_reader (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                job_fetch_complete,
    input  logic                                prime_en,
    input  logic                                row_load_en,
    input  logic                                clear,
    input  logic [cnn_accel_pkg::PFB_CNT_W-1:0] pfb_full_count,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]    num_input_cols,
    output logic                                pfb_rden,
    output logic                                pfb_empty,
    output logic                                prime_done,
    output logic                                row_loaded,
    output logic [cnn_accel_pkg::ADDR_W-1:0]    input_row,
    output logic [cnn_accel_pkg::ADDR_W-1:0]    input_col
);
    import cnn_accel_pkg::*;

    // Words left in the prefetch buffer
    logic [PFB_CNT_W-1:0] pfb_count;
    logic                 rd_en;
    logic                 col_wrap;

    assign rd_en      = prime_en || row_load_en;
    // Last column of a row being read
    assign col_wrap   = pfb_rden && (input_col == num_input_cols);
    assign pfb_empty  = (pfb_count == '0);
    assign prime_done = (input_row >= ADDR_W'(PRIME_ROWS));
    assign row_loaded = row_load_en && col_wrap;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            pfb_count <= '0;
            pfb_rden  <= 1'b0;
            input_row <= '0;
            input_col <= '0;
        end else begin
            // Stop one early when the last word is already in flight
            pfb_rden <= rd_en && ((pfb_count > 1) || (pfb_count == 1 && !pfb_rden));
            if (job_fetch_complete) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
            // Input position follows every read
            if (col_wrap) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else if (pfb_rden) begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    a_rden_nonzero: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> pfb_count != '0)
        else $error("PFB read with empty word count");

endmodule

// ==== design/seq_read_timer.sv ====
`timescale 1ns/1ps

module seq_read_timer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 seq_en,
    input  logic                                 seq_restart,
    input  logic                                 clear,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_output_cols,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_output_rows,
    output logic                                 seq_rden,
    output logic                                 row_done,
    output logic                                 last_row,
    output logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] seq_addr
);
    import cnn_accel_pkg::*;

    // Address of the next read
    logic [SEQ_ADDR_W-1:0] rd_ptr;
    logic [SEQ_ADDR_W-1:0] pass_len;
    logic [2:0]            cycle_cnt;
    logic [ADDR_W-1:0]     output_col;
    logic [ADDR_W-1:0]     output_row;

    // Reads in one output row pass
    assign pass_len = (SEQ_ADDR_W'(num_output_cols) + 1'b1) * (SEQ_ADDR_W'(CYCLE_COUNT) + 1'b1);

    // Final read of the last pixel in the row
    assign row_done = seq_rden && (cycle_cnt == CYCLE_COUNT) && (output_col == num_output_cols);
    assign last_row = (output_row == num_output_rows);

    ////////////////////////////////////////
    // Read enable and address
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            seq_rden   <= 1'b0;
            rd_ptr     <= '0;
            seq_addr   <= '0;
            cycle_cnt  <= '0;
            output_col <= '0;
            output_row <= '0;
        end else begin
            // Back-to-back reads until the pass ends
            seq_rden <= seq_en && !row_done;
            if (seq_restart) begin
                rd_ptr     <= '0;
                cycle_cnt  <= '0;
                output_col <= '0;
            end else if (seq_rden) begin
                // Address lines up with the registered BRAM enable
                seq_addr <= rd_ptr;
                if (row_done) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                // Pixel boundary
                if (cycle_cnt == CYCLE_COUNT) begin
                    cycle_cnt <= '0;
                    if (output_col == num_output_cols) begin
                        output_col <= '0;
                        output_row <= output_row + 1'b1;
                    end else begin
                        output_col <= output_col + 1'b1;
                    end
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

    a_addr_in_pass: assert property (@(posedge clk) disable iff (rst)
        seq_addr < pass_len)
        else $error("sequence address %0d beyond pass length %0d", seq_addr, pass_len);

endmodule

// ==== design/ce_exec_pipeline.sv ====
`timescale 1ns/1ps

module ce_exec_pipeline (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            seq_rden,
    input  logic                            row_done,
    output logic                            pix_seq_bram_rden,
    output logic [cnn_accel_pkg::NUM_CE-1:0] ce_execute,
    output logic [cnn_accel_pkg::NUM_CE-1:0] next_kernel
);
    import cnn_accel_pkg::*;

    // Read latency stages followed by one stage per CE
    localparam int SR_LEN = SEQ_RD_LATENCY + NUM_CE - 1;

    logic [SR_LEN-1:0] exec_sr;
    logic [SR_LEN-1:0] kern_sr;

    ////////////////////////////////////////
    // Delay and CE shift chains
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_sr <= '0;
            kern_sr <= '0;
        end else begin
            exec_sr <= {exec_sr[SR_LEN-2:0], seq_rden};
            // End of row becomes the next-kernel strobe
            kern_sr <= {kern_sr[SR_LEN-2:0], row_done};
        end
    end

    // First stage drives the BRAM port
    assign pix_seq_bram_rden = exec_sr[0];

    // CE k sees data SEQ_RD_LATENCY+k cycles after the read
    assign ce_execute  = exec_sr[SR_LEN-1:SEQ_RD_LATENCY-1];
    assign next_kernel = kern_sr[SR_LEN-1:SEQ_RD_LATENCY-1];

endmodule

// ==== design/quad_bram_ctrl.sv ====
`timescale 1ns/1ps

module quad_bram_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_input_cols,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_input_rows,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_output_cols,
    input  logic [cnn_accel_pkg::ADDR_W-1:0]     num_output_rows,
    input  logic                                 job_start,
    input  logic                                 job_fetch_ack,
    input  logic                                 job_fetch_complete,
    input  logic                                 job_complete_ack,
    input  logic                                 pipeline_flushed,
    input  logic [cnn_accel_pkg::PFB_CNT_W-1:0]  pfb_full_count,
    output logic                                 job_accept,
    output logic                                 job_fetch_request,
    output logic                                 job_fetch_in_progress,
    output logic                                 job_complete,
    output logic                                 pfb_rden,
    output logic                                 pix_seq_bram_rden,
    output logic [cnn_accel_pkg::ADDR_W-1:0]     input_row,
    output logic [cnn_accel_pkg::ADDR_W-1:0]     input_col,
    output logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] pix_seq_bram_rdaddr,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     ce_execute,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     next_kernel,
    output cnn_accel_pkg::quad_state_t           state
);

    // FSM to PFB reader
    logic prime_en;
    logic row_load_en;
    logic prime_done;
    logic row_loaded;
    logic pfb_empty;
    // FSM to sequence timer
    logic seq_en;
    logic seq_restart;
    logic row_done;
    logic last_row;
    logic seq_rden;
    logic clear;

    quad_ctrl_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pipeline_flushed      (pipeline_flushed),
        .prime_done            (prime_done),
        .row_loaded            (row_loaded),
        .pfb_empty             (pfb_empty),
        .row_done              (row_done),
        .last_row              (last_row),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .prime_en              (prime_en),
        .row_load_en           (row_load_en),
        .seq_en                (seq_en),
        .seq_restart           (seq_restart),
        .clear                 (clear),
        .state                 (state)
    );

    pfb_row_reader u_pfb_reader (
        .clk                (clk),
        .rst                (rst),
        .job_fetch_complete (job_fetch_complete),
        .prime_en           (prime_en),
        .row_load_en        (row_load_en),
        .clear              (clear),
        .pfb_full_count     (pfb_full_count),
        .num_input_cols     (num_input_cols),
        .pfb_rden           (pfb_rden),
        .pfb_empty          (pfb_empty),
        .prime_done         (prime_done),
        .row_loaded         (row_loaded),
        .input_row          (input_row),
        .input_col          (input_col)
    );

    seq_read_timer u_seq_timer (
        .clk             (clk),
        .rst             (rst),
        .seq_en          (seq_en),
        .seq_restart     (seq_restart),
        .clear           (clear),
        .num_output_cols (num_output_cols),
        .num_output_rows (num_output_rows),
        .seq_rden        (seq_rden),
        .row_done        (row_done),
        .last_row        (last_row),
        .seq_addr        (pix_seq_bram_rdaddr)
    );

    ce_exec_pipeline u_ce_pipe (
        .clk               (clk),
        .rst               (rst),
        .seq_rden          (seq_rden),
        .row_done          (row_done),
        .pix_seq_bram_rden (pix_seq_bram_rden),
        .ce_execute        (ce_execute),
        .next_kernel       (next_kernel)
    );

    // Row fetches never run past the last input row of the layer
    a_row_in_layer: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> input_row <= num_input_rows)
        else $error("PFB read at input row %0d past layer end", input_row);

endmodule

// ==== bench/tb_quad_bram_ctrl.sv ====
`timescale 1ns/1ps

module tb_quad_bram_ctrl;
    import cnn_accel_pkg::*;

    // Cycles allowed for any single wait
    localparam int TIMEOUT = 200;

    logic                  clk;
    logic                  rst;
    logic [ADDR_W-1:0]     num_input_cols;
    logic [ADDR_W-1:0]     num_input_rows;
    logic [ADDR_W-1:0]     num_output_cols;
    logic [ADDR_W-1:0]     num_output_rows;
    logic                  job_start;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic                  job_complete_ack;
    logic                  pipeline_flushed;
    logic [PFB_CNT_W-1:0]  pfb_full_count;
    logic                  job_accept;
    logic                  job_fetch_request;
    logic                  job_fetch_in_progress;
    logic                  job_complete;
    logic                  pfb_rden;
    logic                  pix_seq_bram_rden;
    logic [ADDR_W-1:0]     input_row;
    logic [ADDR_W-1:0]     input_col;
    logic [SEQ_ADDR_W-1:0] pix_seq_bram_rdaddr;
    logic [NUM_CE-1:0]     ce_execute;
    logic [NUM_CE-1:0]     next_kernel;
    quad_state_t           state;

    int checks;
    int errors;
    int mark_checks;
    int mark_errors;
    // Sizes of the job in flight
    int cur_in_cols;
    int cur_out_cols;
    int cur_out_rows;
    // Per-job observations
    int accepts;
    int fetch_acks;
    int fetch_reads;
    int passes;
    int pass_pos;
    int kernels;
    int exp_col;
    int exp_row;
    bit exp_in_progress;
    bit after_reset;
    bit prev_complete;
    bit prev_complete_ack;
    bit prev_fetch_ack;
    // Bit 0 is the current sample
    logic [15:0] rden_hist;
    logic [15:0] end_hist;

    quad_bram_ctrl DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Sequence reads in one output row pass
    function automatic int reads_per_pass(input int out_cols);
        return (out_cols + 1) * (int'(CYCLE_COUNT) + 1);
    endfunction

    // Priming rows plus one row after each pass but the last
    function automatic int fetches_per_job(input int out_rows);
        return PRIME_ROWS + out_rows;
    endfunction

    function automatic int words_per_fetch(input int in_cols);
        return in_cols + 1;
    endfunction

    task automatic check_cond(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: no %s within %0d cycles at %0t ns", what, TIMEOUT, $time);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    ////////////////////////////////////////
    // Comparing process, mid-cycle samples
    ////////////////////////////////////////

    always @(negedge clk) begin
        logic              last_read;
        logic [NUM_CE-1:0] exp_ce;
        logic [NUM_CE-1:0] exp_nk;
        if (rst) begin
            {accepts, fetch_acks, fetch_reads, passes, pass_pos, kernels} = '0;
            exp_col = 0;
            exp_row = 0;
            exp_in_progress = 1'b0;
            {prev_complete, prev_complete_ack, prev_fetch_ack} = '0;
            rden_hist = '0;
            end_hist = '0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_cond(!job_accept && !job_fetch_request && !job_fetch_in_progress
                           && !job_complete && !pfb_rden && !pix_seq_bram_rden
                           && ce_execute == '0 && next_kernel == '0 && state == ST_IDLE,
                           "control outputs not idle after reset");
                after_reset = 1'b0;
            end
            if (job_accept)
                accepts++;
            // Fetch handshake
            check_cond(!(job_fetch_request && job_fetch_in_progress),
                       "fetch request high during fetch in progress");
            check_cond(job_fetch_in_progress == exp_in_progress,
                       $sformatf("job_fetch_in_progress %0b, expected %0b",
                                 job_fetch_in_progress, exp_in_progress));
            if (prev_fetch_ack)
                check_cond(!job_fetch_request, "fetch request held after acknowledge");
            if (job_fetch_ack) begin
                check_cond(job_fetch_request, "fetch acknowledge with no request pending");
                fetch_acks++;
                exp_in_progress = 1'b1;
            end
            if (job_fetch_complete) begin
                check_cond(fetch_reads == (fetch_acks == 1 ? 0 : words_per_fetch(cur_in_cols)),
                           $sformatf("%0d PFB reads in previous fetch", fetch_reads));
                fetch_reads = 0;
                exp_in_progress = 1'b0;
            end
            // Input position wraps at the last column
            if (pfb_rden) begin
                check_cond(input_col == exp_col && input_row == exp_row,
                           $sformatf("PFB read at row %0d col %0d, expected row %0d col %0d",
                                     input_row, input_col, exp_row, exp_col));
                fetch_reads++;
                if (exp_col == cur_in_cols) begin
                    exp_col = 0;
                    exp_row++;
                end else begin
                    exp_col++;
                end
            end
            if (state == ST_ACTIVE)
                check_cond(input_row >= PRIME_ROWS, "active pass before priming rows loaded");
            // CE chains against the read history
            last_read = pix_seq_bram_rden && (pass_pos == reads_per_pass(cur_out_cols) - 1);
            rden_hist = {rden_hist[14:0], pix_seq_bram_rden};
            end_hist = {end_hist[14:0], last_read};
            for (int k = 0; k < NUM_CE; k++) begin
                exp_ce[k] = rden_hist[SEQ_RD_LATENCY + k - 1];
                exp_nk[k] = end_hist[SEQ_RD_LATENCY + k - 1];
            end
            check_cond(ce_execute == exp_ce && next_kernel == exp_nk,
                       $sformatf("ce_execute %b next_kernel %b, expected %b %b",
                                 ce_execute, next_kernel, exp_ce, exp_nk));
            if (next_kernel[0])
                kernels++;
            // Gapless addresses from 0 in each pass
            if (pix_seq_bram_rden) begin
                check_cond(pix_seq_bram_rdaddr == pass_pos,
                           $sformatf("sequence address %0d, expected %0d",
                                     pix_seq_bram_rdaddr, pass_pos));
                if (last_read) begin
                    passes++;
                    pass_pos = 0;
                end else begin
                    pass_pos++;
                end
            end else begin
                check_cond(pass_pos == 0, $sformatf("pass stopped at read %0d", pass_pos));
            end
            if (job_complete)
                check_cond(pipeline_flushed, "job_complete before pipeline flushed");
            // Acknowledge sampled one cycle ago must have dropped job_complete
            if (prev_complete_ack)
                check_cond(!job_complete, "job_complete held after acknowledge");
            // End of job totals
            if (prev_complete && !job_complete) begin
                check_cond(prev_complete_ack, "job_complete dropped with no acknowledge");
                check_cond(accepts == 1, $sformatf("%0d job_accept pulses", accepts));
                check_cond(fetch_acks == fetches_per_job(cur_out_rows),
                           $sformatf("%0d fetches, expected %0d", fetch_acks,
                                     fetches_per_job(cur_out_rows)));
                check_cond(fetch_reads == words_per_fetch(cur_in_cols),
                           $sformatf("%0d PFB reads in last fetch", fetch_reads));
                check_cond(passes == cur_out_rows + 1 && kernels == cur_out_rows + 1,
                           $sformatf("%0d passes and %0d next_kernel pulses, expected %0d",
                                     passes, kernels, cur_out_rows + 1));
                {accepts, fetch_acks, fetch_reads, passes, kernels} = '0;
                exp_col = 0;
                exp_row = 0;
            end
            prev_complete = job_complete;
            prev_complete_ack = job_complete_ack;
            prev_fetch_ack = job_fetch_ack;
        end
    end

    ////////////////////////////////////////
    // Host model
    ////////////////////////////////////////

    task automatic run_job(input int in_cols, input int out_cols, input int out_rows);
        int cnt;
        bit busy;
        cur_in_cols = in_cols;
        cur_out_cols = out_cols;
        cur_out_rows = out_rows;
        @(posedge clk);
        num_input_cols <= ADDR_W'(in_cols);
        num_input_rows <= ADDR_W'(out_rows + PRIME_ROWS - 1);
        num_output_cols <= ADDR_W'(out_cols);
        num_output_rows <= ADDR_W'(out_rows);
        pfb_full_count <= PFB_CNT_W'(words_per_fetch(in_cols));
        job_start <= 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!job_accept && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!job_accept)
            timeout_fail("job_accept");
        job_start <= 1'b0;
        // Answer fetches until the last pass ends
        busy = 1'b1;
        while (busy) begin
            cnt = 0;
            while (!job_fetch_request && state != ST_WAIT_JOB_DONE && cnt < TIMEOUT) begin
                @(posedge clk);
                cnt++;
            end
            if (!job_fetch_request && state != ST_WAIT_JOB_DONE)
                timeout_fail("fetch request or end of passes");
            if (job_fetch_request) begin
                idle_cycles($urandom % 6);
                job_fetch_ack <= 1'b1;
                @(posedge clk);
                job_fetch_ack <= 1'b0;
                cnt = 0;
                while (!job_fetch_in_progress && cnt < TIMEOUT) begin
                    @(posedge clk);
                    cnt++;
                end
                if (!job_fetch_in_progress)
                    timeout_fail("job_fetch_in_progress");
                idle_cycles($urandom % 6);
                job_fetch_complete <= 1'b1;
                @(posedge clk);
                job_fetch_complete <= 1'b0;
            end else begin
                busy = 1'b0;
            end
        end
        // Flush only once the CE chains are empty
        cnt = 0;
        while ((ce_execute != '0 || next_kernel != '0) && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (ce_execute != '0 || next_kernel != '0)
            timeout_fail("drain of the CE chains");
        idle_cycles($urandom % 6);
        pipeline_flushed <= 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!job_complete && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!job_complete)
            timeout_fail("job_complete");
        idle_cycles($urandom % 6);
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
        pipeline_flushed <= 1'b0;
        cnt = 0;
        while (state != ST_IDLE && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (state != ST_IDLE)
            timeout_fail("return to idle");
    endtask

    initial begin
        void'($urandom(93));
        rst = 1'b1;
        num_input_cols = '0;
        num_input_rows = '0;
        num_output_cols = '0;
        num_output_rows = '0;
        job_start = 1'b0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        pfb_full_count = '0;
        checks = 0;
        errors = 0;
        mark_checks = 0;
        mark_errors = 0;
        {cur_in_cols, cur_out_cols, cur_out_rows} = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(3);
        report_test("reset values");
        // Kernel of four rows, input is output plus three
        run_job(6, 3, 2);
        report_test("first job");
        run_job(8, 5, 3);
        report_test("second job");
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== src.f ====
design/cnn_accel_pkg.sv
design/quad_ctrl_fsm.sv
design/pfb_row_reader.sv
design/seq_read_timer.sv
design/ce_exec_pipeline.sv
design/quad_bram_ctrl.sv
bench/tb_quad_bram_ctrl.sv

// ==== Bender.yml ====
package:
  name: quad_bram_ctrl

sources:
  - design/cnn_accel_pkg.sv
  - design/quad_ctrl_fsm.sv
  - design/pfb_row_reader.sv
  - design/seq_read_timer.sv
  - design/ce_exec_pipeline.sv
  - design/quad_bram_ctrl.sv
  - target: test
    files:
      - bench/tb_quad_bram_ctrl.sv
